//--- ex_stage.f
logic/ex_stage_pkg.sv
logic/mem_req_if.sv
logic/axil_if.sv
logic/ex_alu.sv
logic/ex_lsu.sv
logic/lsu_axil_master.sv
logic/axil_data_ram.sv
logic/ex_stage_top.sv
bench/ex_stage_tb.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - logic/ex_stage_pkg.sv
  - logic/mem_req_if.sv
  - logic/axil_if.sv
  - logic/ex_alu.sv
  - logic/ex_lsu.sv
  - logic/lsu_axil_master.sv
  - logic/axil_data_ram.sv
  - logic/ex_stage_top.sv
  - target: simulation
    files:
      - bench/ex_stage_tb.sv

//--- bench/ex_stage_tb.sv
// ========================================
// ex_stage_tb
// directed testbench for the execute slice
// with an ALU model and a shadow data memory
// ========================================

`timescale 1ns/1ps

module ex_stage_tb;

	localparam int mem_words    = 256;
	localparam int idx_w        = $clog2(mem_words);
	localparam int n_rand       = 6;
	localparam int n_mem_rounds = 28;
	localparam int n_bp         = 24;
	localparam int n_alu_ops    = 10 * 2 * (64 + n_rand) + 10 * n_rand;
	localparam int n_ops        = n_alu_ops + mem_words + 2 * n_mem_rounds + 16 + 9 + n_bp;

	logic                        clk;
	logic                        reset;
	logic                        op_valid;
	logic                        op_ready;
	ex_stage_pkg::alu_op_e       alu_op;
	ex_stage_pkg::mem_op_e       mem_op;
	logic                        word;
	logic                        pass;
	ex_stage_pkg::data_t         opnd1;
	ex_stage_pkg::data_t         opnd2;
	ex_stage_pkg::data_t         store_data;
	logic                        result_valid;
	logic                        result_ready;
	ex_stage_pkg::data_t         result;
	logic                        except;
	ex_stage_pkg::except_cause_e except_cause;

	int          errors = 0;
	int          ops_sent = 0;
	int          accepted = 0;
	int          taken = 0;
	logic        stall_en = 1'b0;
	logic [31:0] lfsr_state = 32'hd4c7;

	ex_stage_pkg::data_t shadow [mem_words];
	ex_stage_pkg::data_t edge_vals [8] = '{
		64'h0, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff,
		64'h0000_0000_8000_0000, 64'd31, 64'd32, 64'd63
	};

	ex_stage_top #(
		.MEM_WORDS (mem_words)
	) dut_i (
		.clk          (clk),
		.reset        (reset),
		.op_valid     (op_valid),
		.op_ready     (op_ready),
		.alu_op       (alu_op),
		.mem_op       (mem_op),
		.word         (word),
		.pass         (pass),
		.opnd1        (opnd1),
		.opnd2        (opnd2),
		.store_data   (store_data),
		.result_valid (result_valid),
		.result_ready (result_ready),
		.result       (result),
		.except       (except),
		.except_cause (except_cause)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// handshakes counted where all signals are settled
	always @(negedge clk) begin
		if (!reset) begin
			if (op_valid && op_ready) accepted++;
			if (result_valid && result_ready) taken++;
		end
	end

	initial begin
		repeat (n_ops * 20) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", n_ops * 20);
		$display("ERRORS FOUND");
		$finish;
	end

	// galois lfsr, one step per bit taken
	function automatic ex_stage_pkg::data_t take_bits(int n);
		ex_stage_pkg::data_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hd000_0001 : lfsr_state >> 1;
		end
		return v;
	endfunction

	function automatic ex_stage_pkg::data_t alu_model(ex_stage_pkg::alu_op_e aop, logic wd,
			logic ps, ex_stage_pkg::data_t a, ex_stage_pkg::data_t b);
		logic [31:0]         lo;
		ex_stage_pkg::data_t r;
		int                  sh;
		if (ps) return a;
		if (wd) begin
			sh = b[4:0];
			case (aop)
				ex_stage_pkg::alu_add:  lo = a[31:0] + b[31:0];
				ex_stage_pkg::alu_sub:  lo = a[31:0] - b[31:0];
				ex_stage_pkg::alu_sll:  lo = a[31:0] << sh;
				ex_stage_pkg::alu_slt:  lo = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				ex_stage_pkg::alu_sltu: lo = (a < b) ? 32'd1 : 32'd0;
				ex_stage_pkg::alu_xor:  lo = a[31:0] ^ b[31:0];
				ex_stage_pkg::alu_srl:  lo = a[31:0] >> sh;
				ex_stage_pkg::alu_sra:  lo = $signed(a[31:0]) >>> sh;
				ex_stage_pkg::alu_or:   lo = a[31:0] | b[31:0];
				ex_stage_pkg::alu_and:  lo = a[31:0] & b[31:0];
				default:                lo = '0;
			endcase
			return {{32{lo[31]}}, lo};
		end
		sh = b[5:0];
		case (aop)
			ex_stage_pkg::alu_add:  r = a + b;
			ex_stage_pkg::alu_sub:  r = a - b;
			ex_stage_pkg::alu_sll:  r = a << sh;
			ex_stage_pkg::alu_slt:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			ex_stage_pkg::alu_sltu: r = (a < b) ? 64'd1 : 64'd0;
			ex_stage_pkg::alu_xor:  r = a ^ b;
			ex_stage_pkg::alu_srl:  r = a >> sh;
			ex_stage_pkg::alu_sra:  r = $signed(a) >>> sh;
			ex_stage_pkg::alu_or:   r = a | b;
			ex_stage_pkg::alu_and:  r = a & b;
			default:                r = '0;
		endcase
		return r;
	endfunction

	function automatic int access_bytes(ex_stage_pkg::mem_op_e mop);
		case (mop)
			ex_stage_pkg::mem_lb, ex_stage_pkg::mem_lbu, ex_stage_pkg::mem_sb: return 1;
			ex_stage_pkg::mem_lh, ex_stage_pkg::mem_lhu, ex_stage_pkg::mem_sh: return 2;
			ex_stage_pkg::mem_lw, ex_stage_pkg::mem_lwu, ex_stage_pkg::mem_sw: return 4;
			default: return 8;
		endcase
	endfunction

	function automatic ex_stage_pkg::data_t load_model(ex_stage_pkg::mem_op_e mop,
			ex_stage_pkg::addr_t addr);
		ex_stage_pkg::data_t raw;
		ex_stage_pkg::data_t mask;
		int                  nb;
		nb = access_bytes(mop);
		raw = shadow[addr / 8] >> (8 * addr[2:0]);
		if (nb == 8) return raw;
		mask = (64'h1 << (8 * nb)) - 1;
		raw = raw & mask;
		if (mop inside {ex_stage_pkg::mem_lb, ex_stage_pkg::mem_lh, ex_stage_pkg::mem_lw}
				&& raw[8 * nb - 1])
			raw = raw | ~mask;  // sign extension
		return raw;
	endfunction

	function automatic ex_stage_pkg::data_t fill_word(int i);
		logic [31:0] a;
		a = i * 8;
		return {~a, a * 32'h9e37_79b9};
	endfunction

	task automatic check_data(string name, ex_stage_pkg::data_t got, ex_stage_pkg::data_t exp);
		if (got !== exp) begin
			errors++;
			$display("error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_cause(string name, ex_stage_pkg::except_cause_e got,
			ex_stage_pkg::except_cause_e exp);
		if (got !== exp) begin
			errors++;
			$display("error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			errors++;
			$display("error: %s got %h expected %h", name, got, exp);
		end
	endtask

	// called 1 ns after a rising edge, returns 1 ns after the edge that took the result
	task automatic run_op(ex_stage_pkg::alu_op_e aop, ex_stage_pkg::mem_op_e mop, logic wd,
			logic ps, ex_stage_pkg::data_t a, ex_stage_pkg::data_t b, ex_stage_pkg::data_t sd,
			ex_stage_pkg::data_t exp_res, logic chk_res, ex_stage_pkg::except_cause_e exp_cause,
			logic fixed);
		int                          cycles;
		int                          hold;
		ex_stage_pkg::data_t         held;
		ex_stage_pkg::except_cause_e held_cause;
		hold = stall_en ? 1 + int'(take_bits(2)) : 0;
		alu_op = aop;
		mem_op = mop;
		word = wd;
		pass = ps;
		opnd1 = a;
		opnd2 = b;
		store_data = sd;
		op_valid = 1'b1;
		result_ready = hold == 0;
		ops_sent++;
		cycles = 0;
		while (!op_ready && cycles < 40) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		@(posedge clk);  // accepted here
		#1;
		op_valid = 1'b0;
		cycles = 0;
		while (!result_valid && cycles < 40) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!result_valid) begin
			errors++;
			$display("no result within 40 cycles of accepting operation %0d", ops_sent);
			result_ready = 1'b1;
			return;
		end
		if (fixed && cycles != 1) begin
			errors++;
			$display("result came %0d cycles after acceptance instead of 1", cycles);
		end
		if (chk_res) check_data("result", result, exp_res);
		check_flag("except", except, exp_cause != ex_stage_pkg::cause_none);
		check_cause("except_cause", except_cause, exp_cause);
		held = result;
		held_cause = except_cause;
		while (hold > 0) begin
			@(posedge clk);
			#1;
			hold--;
			check_flag("result_valid", result_valid, 1'b1);
			check_flag("op_ready", op_ready, 1'b0);
			check_data("result", result, held);
			check_cause("except_cause", except_cause, held_cause);
		end
		result_ready = 1'b1;
		@(posedge clk);
		#1;
		check_flag("result_valid", result_valid, 1'b0);  // taken exactly once
	endtask

	task automatic run_alu(ex_stage_pkg::alu_op_e aop, logic wd, logic ps,
			ex_stage_pkg::data_t a, ex_stage_pkg::data_t b);
		run_op(aop, ex_stage_pkg::mem_none, wd, ps, a, b, '0, alu_model(aop, wd, ps, a, b),
			1'b1, ex_stage_pkg::cause_none, 1'b1);
	endtask

	task automatic run_store(ex_stage_pkg::mem_op_e mop, ex_stage_pkg::addr_t addr,
			ex_stage_pkg::data_t sd, ex_stage_pkg::except_cause_e exp_cause);
		ex_stage_pkg::data_t off;
		int                  nb;
		off = take_bits(3);
		run_op(ex_stage_pkg::alu_add, mop, 1'b0, 1'b0, ex_stage_pkg::data_t'(addr) - off, off,
			sd, ex_stage_pkg::data_t'(addr), exp_cause == ex_stage_pkg::cause_none, exp_cause,
			exp_cause == ex_stage_pkg::cause_store_misalign);
		if (exp_cause == ex_stage_pkg::cause_none) begin
			nb = access_bytes(mop);
			for (int k = 0; k < nb; k++)
				shadow[addr / 8][(addr[2:0] + k) * 8 +: 8] = sd[k * 8 +: 8];
		end
	endtask

	task automatic run_load(ex_stage_pkg::mem_op_e mop, ex_stage_pkg::addr_t addr,
			ex_stage_pkg::except_cause_e exp_cause);
		ex_stage_pkg::data_t off;
		ex_stage_pkg::data_t exp;
		off = take_bits(3);
		exp = (exp_cause == ex_stage_pkg::cause_none) ? load_model(mop, addr) : '0;
		run_op(ex_stage_pkg::alu_add, mop, 1'b0, 1'b0, ex_stage_pkg::data_t'(addr) - off, off,
			'0, exp, exp_cause == ex_stage_pkg::cause_none, exp_cause,
			exp_cause == ex_stage_pkg::cause_load_misalign);
	endtask

	task automatic test_alu_ops();
		ex_stage_pkg::alu_op_e aop;
		for (int op_i = 0; op_i < 10; op_i++) begin
			aop = ex_stage_pkg::alu_op_e'(op_i);
			for (int wd = 0; wd < 2; wd++) begin
				for (int i = 0; i < 8; i++)
					for (int j = 0; j < 8; j++)
						run_alu(aop, wd[0], 1'b0, edge_vals[i], edge_vals[j]);
				for (int r = 0; r < n_rand; r++)
					run_alu(aop, wd[0], 1'b0, take_bits(64), take_bits(64));
			end
			for (int r = 0; r < n_rand; r++)
				run_alu(aop, r[0], 1'b1, take_bits(64), take_bits(64));
		end
	endtask

	task automatic fill_memory();
		for (int i = 0; i < mem_words; i++)
			run_store(ex_stage_pkg::mem_sd, i * 8, fill_word(i), ex_stage_pkg::cause_none);
	endtask

	task automatic test_mem_widths();
		ex_stage_pkg::mem_op_e store_ops [4] = '{ex_stage_pkg::mem_sb, ex_stage_pkg::mem_sh,
			ex_stage_pkg::mem_sw, ex_stage_pkg::mem_sd};
		ex_stage_pkg::mem_op_e load_ops [7] = '{ex_stage_pkg::mem_lb, ex_stage_pkg::mem_lh,
			ex_stage_pkg::mem_lw, ex_stage_pkg::mem_ld, ex_stage_pkg::mem_lbu,
			ex_stage_pkg::mem_lhu, ex_stage_pkg::mem_lwu};
		int idx;
		int nb;
		int lane;
		for (int r = 0; r < n_mem_rounds; r++) begin
			idx = int'(take_bits(idx_w));
			nb = access_bytes(store_ops[r % 4]);
			lane = (int'(take_bits(3)) / nb) * nb;
			run_store(store_ops[r % 4], idx * 8 + lane, take_bits(64), ex_stage_pkg::cause_none);
			nb = access_bytes(load_ops[r % 7]);
			lane = (int'(take_bits(3)) / nb) * nb;  // same word, any aligned lane
			run_load(load_ops[r % 7], idx * 8 + lane, ex_stage_pkg::cause_none);
		end
	endtask

	task automatic test_misaligned();
		ex_stage_pkg::mem_op_e mis_ops [8] = '{ex_stage_pkg::mem_lh, ex_stage_pkg::mem_lhu,
			ex_stage_pkg::mem_lw, ex_stage_pkg::mem_lwu, ex_stage_pkg::mem_ld,
			ex_stage_pkg::mem_sh, ex_stage_pkg::mem_sw, ex_stage_pkg::mem_sd};
		int idx;
		int lane;
		for (int i = 0; i < 8; i++) begin
			idx = int'(take_bits(idx_w));
			lane = (i % 2) ? access_bytes(mis_ops[i]) / 2 : 2 * int'(take_bits(2)) + 1;
			if (ex_stage_pkg::is_store(mis_ops[i]))
				run_store(mis_ops[i], idx * 8 + lane, take_bits(64),
					ex_stage_pkg::cause_store_misalign);
			else
				run_load(mis_ops[i], idx * 8 + lane, ex_stage_pkg::cause_load_misalign);
			run_load(ex_stage_pkg::mem_ld, idx * 8, ex_stage_pkg::cause_none);
		end
	endtask

	task automatic test_faults();
		ex_stage_pkg::addr_t bad [3] = '{mem_words * 8, mem_words * 8 + 8, 32'hffff_fff8};
		for (int i = 0; i < 3; i++) begin
			run_store(ex_stage_pkg::mem_sd, bad[i], take_bits(64), ex_stage_pkg::cause_store_fault);
			run_load(ex_stage_pkg::mem_ld, bad[i], ex_stage_pkg::cause_load_fault);
		end
		// the word lines that the bad addresses alias onto
		run_load(ex_stage_pkg::mem_ld, 0, ex_stage_pkg::cause_none);
		run_load(ex_stage_pkg::mem_ld, 8, ex_stage_pkg::cause_none);
		run_load(ex_stage_pkg::mem_ld, (mem_words - 1) * 8, ex_stage_pkg::cause_none);
	endtask

	task automatic test_backpressure();
		int idx;
		stall_en = 1'b1;
		for (int r = 0; r < n_bp; r++) begin
			idx = int'(take_bits(idx_w));
			case (r % 3)
				0: run_alu(ex_stage_pkg::alu_op_e'(take_bits(4) % 10), take_bits(1), 1'b0,
					take_bits(64), take_bits(64));
				1: run_store(ex_stage_pkg::mem_sd, idx * 8, take_bits(64), ex_stage_pkg::cause_none);
				default: run_load(ex_stage_pkg::mem_lw, idx * 8 + 4, ex_stage_pkg::cause_none);
			endcase
		end
		stall_en = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		op_valid = 1'b0;
		alu_op = ex_stage_pkg::alu_add;
		mem_op = ex_stage_pkg::mem_none;
		word = 1'b0;
		pass = 1'b0;
		opnd1 = '0;
		opnd2 = '0;
		store_data = '0;
		result_ready = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		check_flag("op_ready", op_ready, 1'b1);
		check_flag("result_valid", result_valid, 1'b0);
		test_alu_ops();
		fill_memory();
		test_mem_widths();
		test_misaligned();
		test_faults();
		test_backpressure();
		if (accepted != ops_sent || taken != ops_sent) begin
			errors++;
			$display("operations lost or repeated: %0d sent, %0d accepted, %0d results taken",
				ops_sent, accepted, taken);
		end
		$display("%0d errors in %0d operations", errors, ops_sent);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- logic/ex_stage_top.sv
// ========================================
// ex_stage_top
// execute and memory access slice with its
// AXI4-Lite data RAM
// ========================================

`timescale 1ns/1ps

module ex_stage_top #(
	parameter int MEM_WORDS = 256
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        op_valid,
	output logic                        op_ready,
	input  ex_stage_pkg::alu_op_e       alu_op,  // add for memory ops
	input  ex_stage_pkg::mem_op_e       mem_op,
	input  logic                        word,
	input  logic                        pass,
	input  ex_stage_pkg::data_t         opnd1,
	input  ex_stage_pkg::data_t         opnd2,
	input  ex_stage_pkg::data_t         store_data,
	output logic                        result_valid,
	input  logic                        result_ready,
	output ex_stage_pkg::data_t         result,
	output logic                        except,
	output ex_stage_pkg::except_cause_e except_cause
);

	ex_stage_pkg::ex_req_t op;
	ex_stage_pkg::ex_rsp_t rsp;
	ex_stage_pkg::data_t   alu_result;

	mem_req_if mem_bus ();
	axil_if    axil ();

	assign op.alu_op     = alu_op;
	assign op.mem_op     = mem_op;
	assign op.word       = word;
	assign op.pass       = pass;
	assign op.opnd1      = opnd1;
	assign op.opnd2      = opnd2;
	assign op.store_data = store_data;

	ex_alu alu_i (
		.req        (op),
		.alu_result (alu_result)
	);

	ex_lsu lsu_i (
		.clk          (clk),
		.reset        (reset),
		.op_valid     (op_valid),
		.op           (op),
		.op_ready     (op_ready),
		.alu_result   (alu_result),
		.mem          (mem_bus.requester),
		.result_valid (result_valid),
		.result_ready (result_ready),
		.result       (rsp)
	);

	lsu_axil_master master_i (
		.clk   (clk),
		.reset (reset),
		.mem   (mem_bus.server),
		.bus   (axil.master)
	);

	axil_data_ram #(
		.MEM_WORDS (MEM_WORDS)
	) ram_i (
		.clk   (clk),
		.reset (reset),
		.bus   (axil.slave)
	);

	assign result       = rsp.result;
	assign except       = rsp.except;
	assign except_cause = rsp.cause;

endmodule

//--- logic/axil_data_ram.sv
// ========================================
// axil_data_ram
// AXI4-Lite slave 64-bit data memory, SLVERR
// on out of range addresses
// ========================================

`timescale 1ns/1ps

module axil_data_ram #(
	parameter int MEM_WORDS = 256
) (
	input logic   clk,
	input logic   reset,
	axil_if.slave bus
);

	localparam int          idx_w     = $clog2(MEM_WORDS);
	localparam int unsigned mem_bytes = MEM_WORDS * 8;

	ex_stage_pkg::data_t mem [MEM_WORDS];

	logic             rd_fire;
	logic             wr_fire;
	logic             rd_ok;
	logic             wr_ok;
	logic [idx_w-1:0] rd_idx;
	logic [idx_w-1:0] wr_idx;

	assign bus.arready = bus.arvalid && !bus.rvalid;
	assign bus.awready = bus.awvalid && bus.wvalid && !bus.bvalid;  // AW and W taken together
	assign bus.wready  = bus.awready;

	assign rd_fire = bus.arvalid && bus.arready;
	assign wr_fire = bus.awvalid && bus.awready;

	assign rd_ok  = bus.araddr < mem_bytes;
	assign wr_ok  = bus.awaddr < mem_bytes;
	assign rd_idx = bus.araddr[idx_w+2:3];
	assign wr_idx = bus.awaddr[idx_w+2:3];

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.rvalid <= 1'b0;
			bus.bvalid <= 1'b0;
		end else begin
			if (rd_fire)
				bus.rvalid <= 1'b1;
			else if (bus.rready)
				bus.rvalid <= 1'b0;
			if (wr_fire)
				bus.bvalid <= 1'b1;
			else if (bus.bready)
				bus.bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			bus.rdata <= rd_ok ? mem[rd_idx] : '0;
			bus.rresp <= rd_ok ? ex_stage_pkg::resp_okay : ex_stage_pkg::resp_slverr;
		end
		if (wr_fire) begin
			bus.bresp <= wr_ok ? ex_stage_pkg::resp_okay : ex_stage_pkg::resp_slverr;
			if (wr_ok) begin
				for (int i = 0; i < ex_stage_pkg::xlen / 8; i++)
					if (bus.wstrb[i])
						mem[wr_idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];  // byte merge
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		$rose(bus.bvalid) |-> $past(wr_fire));

endmodule

//--- logic/lsu_axil_master.sv
// ========================================
// lsu_axil_master
// one AXI4-Lite read or write per request
// ========================================

`timescale 1ns/1ps

module lsu_axil_master (
	input logic       clk,
	input logic       reset,
	mem_req_if.server mem,
	axil_if.master    bus
);

	typedef enum logic [1:0] {st_idle, st_read, st_write, st_resp} state_e;

	state_e              state;
	logic                wr_q;
	logic                aw_done;
	logic                w_done;
	ex_stage_pkg::addr_t addr_q;
	ex_stage_pkg::data_t wdata_q;
	ex_stage_pkg::strb_t wstrb_q;
	logic                aw_fire;
	logic                w_fire;
	logic                r_fire;
	logic                b_fire;

	assign mem.ready = state == st_idle;

	assign bus.arvalid = state == st_read;
	assign bus.araddr  = addr_q;
	assign bus.awvalid = state == st_write && !aw_done;
	assign bus.awaddr  = addr_q;
	assign bus.wvalid  = state == st_write && !w_done;
	assign bus.wdata   = wdata_q;
	assign bus.wstrb   = wstrb_q;
	assign bus.rready  = state == st_resp && !wr_q;
	assign bus.bready  = state == st_resp && wr_q;

	assign aw_fire = bus.awvalid && bus.awready;
	assign w_fire  = bus.wvalid && bus.wready;
	assign r_fire  = bus.rvalid && bus.rready;
	assign b_fire  = bus.bvalid && bus.bready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			aw_done <= 1'b0;
			w_done <= 1'b0;
			mem.rsp_valid <= 1'b0;
		end else begin
			mem.rsp_valid <= r_fire || b_fire;
			case (state)
				st_idle: begin
					aw_done <= 1'b0;
					w_done <= 1'b0;
					if (mem.valid)
						state <= mem.write ? st_write : st_read;
				end
				st_read: if (bus.arready) state <= st_resp;
				st_write: begin
					aw_done <= aw_done || aw_fire;  // AW and W may finish apart
					w_done <= w_done || w_fire;
					if ((aw_done || aw_fire) && (w_done || w_fire))
						state <= st_resp;
				end
				st_resp: if (r_fire || b_fire) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && mem.valid) begin
			wr_q <= mem.write;
			addr_q <= mem.addr;
			wdata_q <= mem.wdata;
			wstrb_q <= mem.wstrb;
		end
		if (r_fire) begin
			mem.rdata <= bus.rdata;
			mem.err <= bus.rresp[1];  // slverr or decerr
		end
		if (b_fire)
			mem.err <= bus.bresp[1];
	end

	assert property (@(posedge clk) disable iff (reset)
		bus.awvalid && !bus.awready |=> bus.awvalid && $stable(bus.awaddr));
	assert property (@(posedge clk) disable iff (reset)
		bus.wvalid && !bus.wready |=> bus.wvalid && $stable(bus.wdata));
	assert property (@(posedge clk) disable iff (reset)
		bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr));

endmodule

//--- logic/ex_lsu.sv
// ========================================
// ex_lsu
// operation sequencer, alignment check, store
// lane placement and load extension
// ========================================

`timescale 1ns/1ps

module ex_lsu (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  op_valid,
	input  ex_stage_pkg::ex_req_t op,
	output logic                  op_ready,
	input  ex_stage_pkg::data_t   alu_result,
	mem_req_if.requester          mem,
	output logic                  result_valid,
	input  logic                  result_ready,
	output ex_stage_pkg::ex_rsp_t result
);

	localparam int w = ex_stage_pkg::xlen;

	typedef enum logic [2:0] {st_idle, st_exec, st_req, st_wait, st_done} state_e;

	state_e                state;
	ex_stage_pkg::ex_req_t op_q;
	ex_stage_pkg::data_t   alu_q;  // result or effective address
	ex_stage_pkg::ex_rsp_t rsp_q;
	logic                  ld;
	logic                  st;
	logic                  misalign;
	ex_stage_pkg::strb_t   base_strb;
	logic [5:0]            lane_shift;
	ex_stage_pkg::data_t   lane_data;
	ex_stage_pkg::data_t   load_value;

	assign ld = ex_stage_pkg::is_load(op_q.mem_op);
	assign st = ex_stage_pkg::is_store(op_q.mem_op);
	assign lane_shift = {alu_q[2:0], 3'b000};

	always_comb begin
		case (op_q.mem_op)
			ex_stage_pkg::mem_lh, ex_stage_pkg::mem_lhu, ex_stage_pkg::mem_sh: begin
				misalign = alu_q[0];
				base_strb = 8'h03;
			end
			ex_stage_pkg::mem_lw, ex_stage_pkg::mem_lwu, ex_stage_pkg::mem_sw: begin
				misalign = |alu_q[1:0];
				base_strb = 8'h0f;
			end
			ex_stage_pkg::mem_ld, ex_stage_pkg::mem_sd: begin
				misalign = |alu_q[2:0];
				base_strb = 8'hff;
			end
			default: begin
				misalign = 1'b0;  // bytes are always aligned
				base_strb = 8'h01;
			end
		endcase
	end

	assign mem.valid = state == st_req;
	assign mem.write = st;
	assign mem.addr  = alu_q[31:0];
	assign mem.wdata = op_q.store_data << lane_shift;
	assign mem.wstrb = base_strb << alu_q[2:0];

	assign lane_data = mem.rdata >> lane_shift;

	always_comb begin
		case (op_q.mem_op)
			ex_stage_pkg::mem_lb:  load_value = {{(w-8){lane_data[7]}}, lane_data[7:0]};
			ex_stage_pkg::mem_lh:  load_value = {{(w-16){lane_data[15]}}, lane_data[15:0]};
			ex_stage_pkg::mem_lw:  load_value = {{(w-32){lane_data[31]}}, lane_data[31:0]};
			ex_stage_pkg::mem_lbu: load_value = {{(w-8){1'b0}}, lane_data[7:0]};
			ex_stage_pkg::mem_lhu: load_value = {{(w-16){1'b0}}, lane_data[15:0]};
			ex_stage_pkg::mem_lwu: load_value = {{(w-32){1'b0}}, lane_data[31:0]};
			default:               load_value = lane_data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (op_valid) state <= st_exec;
				st_exec: state <= ((ld || st) && !misalign) ? st_req : st_done;
				st_req:  if (mem.ready) state <= st_wait;
				st_wait: if (mem.rsp_valid) state <= st_done;
				st_done: if (result_ready) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && op_valid) begin
			op_q <= op;
			alu_q <= alu_result;
		end
		if (state == st_exec) begin
			rsp_q.result <= alu_q;
			rsp_q.except <= misalign;
			if (!misalign)
				rsp_q.cause <= ex_stage_pkg::cause_none;
			else
				rsp_q.cause <= st ? ex_stage_pkg::cause_store_misalign
				                  : ex_stage_pkg::cause_load_misalign;
		end
		if (state == st_wait && mem.rsp_valid) begin
			rsp_q.result <= ld ? load_value : alu_q;  // stores return their address
			rsp_q.except <= mem.err;
			if (!mem.err)
				rsp_q.cause <= ex_stage_pkg::cause_none;
			else
				rsp_q.cause <= st ? ex_stage_pkg::cause_store_fault
				                  : ex_stage_pkg::cause_load_fault;
		end
	end

	assign op_ready     = state == st_idle;
	assign result_valid = state == st_done;
	assign result       = rsp_q;

	// output held steady while the consumer stalls
	assert property (@(posedge clk) disable iff (reset)
		result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

//--- logic/ex_alu.sv
// ========================================
// ex_alu
// combinational RV64 integer ALU with word
// forms and operand 1 pass-through
// ========================================

`timescale 1ns/1ps

module ex_alu (
	input  ex_stage_pkg::ex_req_t req,
	output ex_stage_pkg::data_t   alu_result
);

	localparam int w = ex_stage_pkg::xlen;

	ex_stage_pkg::data_t a;
	ex_stage_pkg::data_t b;
	ex_stage_pkg::data_t a_sx;
	ex_stage_pkg::data_t a_zx;
	ex_stage_pkg::data_t raw;
	logic [5:0]          shamt;
	logic                lt_s;
	logic                lt_u;

	assign a = req.opnd1;
	assign b = req.opnd2;

	// operand 1 seen as a 32-bit word
	assign a_sx = {{(w-32){a[31]}}, a[31:0]};
	assign a_zx = {{(w-32){1'b0}}, a[31:0]};

	assign shamt = req.word ? {1'b0, b[4:0]} : b[5:0];  // word shifts use 5 bits

	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	always_comb begin
		case (req.alu_op)
			ex_stage_pkg::alu_add: begin
				raw = a + b;
			end
			ex_stage_pkg::alu_sub: begin
				raw = a - b;
			end
			ex_stage_pkg::alu_sll: begin
				raw = a << shamt;
			end
			ex_stage_pkg::alu_slt: begin
				raw = {{(w-1){1'b0}}, lt_s};
			end
			ex_stage_pkg::alu_sltu: begin
				raw = {{(w-1){1'b0}}, lt_u};
			end
			ex_stage_pkg::alu_xor: begin
				raw = a ^ b;
			end
			ex_stage_pkg::alu_srl: begin
				raw = (req.word ? a_zx : a) >> shamt;
			end
			ex_stage_pkg::alu_sra: begin
				raw = $signed(req.word ? a_sx : a) >>> shamt;  // sign fills from bit 31 or 63
			end
			ex_stage_pkg::alu_or: begin
				raw = a | b;
			end
			ex_stage_pkg::alu_and: begin
				raw = a & b;
			end
			default: begin
				raw = '0;
			end
		endcase
	end

	always_comb begin
		if (req.pass) begin
			alu_result = a;  // system ops carry operand 1
		end else if (req.word) begin
			alu_result = {{(w-32){raw[31]}}, raw[31:0]};
		end else begin
			alu_result = raw;
		end
	end

endmodule

//--- logic/axil_if.sv
// ========================================
// axil_if
// AXI4-Lite channels AW, W, B, AR and R
// ========================================

`timescale 1ns/1ps

interface axil_if;

	logic                awvalid, awready;
	ex_stage_pkg::addr_t awaddr;
	logic                wvalid, wready;
	ex_stage_pkg::data_t wdata;
	ex_stage_pkg::strb_t wstrb;
	logic                bvalid, bready;
	logic [1:0]          bresp;
	logic                arvalid, arready;
	ex_stage_pkg::addr_t araddr;
	logic                rvalid, rready;
	ex_stage_pkg::data_t rdata;
	logic [1:0]          rresp;

	modport master (
		output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
		input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
	);

	modport slave (
		input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
		output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
	);

endinterface

//--- logic/mem_req_if.sv
// ========================================
// mem_req_if
// single memory request and its response
// ========================================

`timescale 1ns/1ps

interface mem_req_if;

	logic                valid;
	logic                ready;
	logic                write;
	ex_stage_pkg::addr_t addr;
	ex_stage_pkg::data_t wdata;
	ex_stage_pkg::strb_t wstrb;

	logic                rsp_valid;  // one cycle pulse
	ex_stage_pkg::data_t rdata;
	logic                err;

	modport requester (
		output valid, write, addr, wdata, wstrb,
		input  ready, rsp_valid, rdata, err
	);

	modport server (
		input  valid, write, addr, wdata, wstrb,
		output ready, rsp_valid, rdata, err
	);

endinterface

//--- logic/ex_stage_pkg.sv
// ========================================
// ex_stage_pkg
// widths, operation encodings and the request
// and response records of the execute slice
// ========================================

package ex_stage_pkg;

	localparam int xlen = 64;

	typedef logic [xlen-1:0]   data_t;
	typedef logic [31:0]       addr_t;
	typedef logic [xlen/8-1:0] strb_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and
	} alu_op_e;

	typedef enum logic [3:0] {
		mem_none, mem_lb, mem_lh, mem_lw, mem_ld, mem_lbu, mem_lhu, mem_lwu,
		mem_sb, mem_sh, mem_sw, mem_sd
	} mem_op_e;

	typedef enum logic [3:0] {
		cause_none           = 4'd0,
		cause_load_misalign  = 4'd4,
		cause_load_fault     = 4'd5,
		cause_store_misalign = 4'd6,
		cause_store_fault    = 4'd7
	} except_cause_e;

	// AXI4-Lite response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	typedef struct packed {
		alu_op_e alu_op;
		mem_op_e mem_op;
		logic    word;  // 32-bit word form
		logic    pass;  // result is operand 1
		data_t   opnd1;
		data_t   opnd2;
		data_t   store_data;
	} ex_req_t;

	typedef struct packed {
		data_t         result;
		logic          except;
		except_cause_e cause;
	} ex_rsp_t;

	function automatic logic is_load(mem_op_e op);
		return op inside {mem_lb, mem_lh, mem_lw, mem_ld, mem_lbu, mem_lhu, mem_lwu};
	endfunction

	function automatic logic is_store(mem_op_e op);
		return op inside {mem_sb, mem_sh, mem_sw, mem_sd};
	endfunction

endpackage
